// File: rtl/fdaPkg.sv
package fdaPkg;

    // ----------------------------------------------------------------------
    // Sample and word widths
    // ----------------------------------------------------------------------

    // One ADC sample
    localparam int SampleW = 8;
    // Four samples per ADC clock edge
    localparam int LanesPerWord = 4;
    localparam int WordW = SampleW * LanesPerWord;
    // Width of one byte on the transmit side
    localparam int ByteW = 8;

    // ----------------------------------------------------------------------
    // Types
    // ----------------------------------------------------------------------

    // Single 8-bit ADC sample
    typedef logic [SampleW-1:0] sampleT;

    // Packed ADC word, top byte first
    // [31:24] DI, [23:16] DId, [15:8] DQ, [7:0] DQd
    typedef logic [WordW-1:0] adcWordT;

    // Byte handed to the transmit side
    typedef logic [ByteW-1:0] byteT;

    // Acquisition FSM states
    typedef enum logic [1:0] {
        AcqIdle  = 2'b00,  // Waiting for arm or forced record
        AcqArmed = 2'b01,  // Waiting for trigger edge
        AcqStore = 2'b10,  // Filling sample memory
        AcqSend  = 2'b11   // Reading record out word by word
    } acqStateT;

endpackage

// File: rtl/sampleCapture.sv
`timescale 1ns/1ps

module sampleCapture
    import fdaPkg::*;
(
    input  logic    ClkADC2DCM,
    input  logic    fifoRecord,
    input  adcWordT adcData,
    input  logic    testMode,
    input  logic    triggerIn,
    output adcWordT sampleWord,
    output logic    trigEdge
);

    // Free-running test ramp
    sampleT rampCnt;

    // Trigger synchronizer, [0] first stage
    logic [1:0] trigSync;
    // Previous synchronized trigger level
    logic trigLast;

    // ----------------------------------------------------------------------
    // Test ramp
    // ----------------------------------------------------------------------

    // Starts at zero after reset, one step per ADC clock
    always_ff @(posedge ClkADC2DCM or posedge fifoRecord) begin
        if (fifoRecord) begin
            rampCnt <= '0;
        end else begin
            // Wraps at 255 back to 0
            rampCnt <= rampCnt + 1'b1;
        end
    end

    // ----------------------------------------------------------------------
    // Sample register
    // ----------------------------------------------------------------------

    // One cycle latency from adcData to sampleWord
    always_ff @(posedge ClkADC2DCM) begin
        if (testMode) begin
            // Same ramp value in all four lanes
            sampleWord <= {LanesPerWord{rampCnt}};
        end else begin
            sampleWord <= adcData;
        end
    end

    // ----------------------------------------------------------------------
    // Trigger synchronizer and edge detect
    // ----------------------------------------------------------------------

    always_ff @(posedge ClkADC2DCM or posedge fifoRecord) begin
        if (fifoRecord) begin
            trigSync <= '0;
            trigLast <= 1'b0;
        end else begin
            // Two flops against metastability
            trigSync <= {trigSync[0], triggerIn};
            // Edge register
            trigLast <= trigSync[1];
        end
    end

    // Rising edge of the synchronized level
    // One cycle wide, driven from flops only
    assign trigEdge = trigSync[1] & ~trigLast;

endmodule

// File: rtl/sampleMemory.sv
`timescale 1ns/1ps

module sampleMemory
    import fdaPkg::*;
#(
    parameter int Depth = 16,
    localparam int AddrW = $clog2(Depth)
) (
    input  logic             ClkADC2DCM,
    input  logic             fifoRecord,
    input  logic             wrEn,
    input  logic [AddrW-1:0] wrAddr,
    input  adcWordT          wrWord,
    input  logic             rdStrobe,
    input  logic [AddrW-1:0] rdAddr,
    output adcWordT          rdWord,
    output logic             rdValid
);

    // Record storage, one ADC word per entry
    adcWordT mem [0:Depth-1];

    // ----------------------------------------------------------------------
    // Write port
    // ----------------------------------------------------------------------

    always_ff @(posedge ClkADC2DCM) begin
        if (wrEn) begin
            mem[wrAddr] <= wrWord;
        end
    end

    // ----------------------------------------------------------------------
    // Registered read port
    // ----------------------------------------------------------------------

    // Data held until the next read strobe
    always_ff @(posedge ClkADC2DCM) begin
        if (rdStrobe) begin
            rdWord <= mem[rdAddr];
        end
    end

    // Valid one cycle behind the strobe
    always_ff @(posedge ClkADC2DCM or posedge fifoRecord) begin
        if (fifoRecord) begin
            rdValid <= 1'b0;
        end else begin
            rdValid <= rdStrobe;
        end
    end

endmodule

// File: rtl/recordControl.sv
`timescale 1ns/1ps

module recordControl
    import fdaPkg::*;
#(
    parameter int Depth = 16,
    localparam int AddrW = $clog2(Depth)
) (
    input  logic             ClkADC2DCM,
    input  logic             fifoRecord,
    input  logic             arm,
    input  logic             forceRecord,
    input  logic             trigEdge,
    input  adcWordT          sampleWord,
    input  logic             wordDone,
    output logic             wrEn,
    output logic [AddrW-1:0] wrAddr,
    output adcWordT          wrWord,
    output logic             rdStrobe,
    output logic [AddrW-1:0] rdAddr,
    output logic             frameDone,
    output acqStateT         acqState
);

    acqStateT state;

    // Write and read counters, both wrap at Depth
    logic [AddrW-1:0] wrCnt;
    logic [AddrW-1:0] rdCnt;

    // Final entry of the record
    logic lastWrite;
    logic lastRead;

    assign lastWrite = (wrCnt == AddrW'(Depth - 1));
    assign lastRead  = (rdCnt == AddrW'(Depth - 1));

    // ----------------------------------------------------------------------
    // Memory side
    // ----------------------------------------------------------------------

    // One write per cycle for the whole store phase
    assign wrEn   = (state == AcqStore);
    assign wrAddr = wrCnt;
    assign wrWord = sampleWord;

    assign rdAddr   = rdCnt;
    assign acqState = state;

    // ----------------------------------------------------------------------
    // Acquisition FSM
    // ----------------------------------------------------------------------

    always_ff @(posedge ClkADC2DCM or posedge fifoRecord) begin
        if (fifoRecord) begin
            state     <= AcqIdle;
            wrCnt     <= '0;
            rdCnt     <= '0;
            rdStrobe  <= 1'b0;
            frameDone <= 1'b0;
        end else begin
            // Strobes default low
            rdStrobe  <= 1'b0;
            frameDone <= 1'b0;

            unique case (state)
                AcqIdle: begin
                    // Forced record wins over arm
                    if (forceRecord) begin
                        state <= AcqStore;
                        wrCnt <= '0;
                        rdCnt <= '0;
                    end else if (arm) begin
                        state <= AcqArmed;
                    end
                end

                AcqArmed: begin
                    // Trigger edge only counts here
                    if (forceRecord || trigEdge) begin
                        state <= AcqStore;
                        wrCnt <= '0;
                        rdCnt <= '0;
                    end
                end

                AcqStore: begin
                    wrCnt <= wrCnt + 1'b1;
                    // Memory full, first read goes out next cycle
                    if (lastWrite) begin
                        state    <= AcqSend;
                        rdStrobe <= 1'b1;
                    end
                end

                AcqSend: begin
                    // Next read only after the sender has finished a word
                    if (wordDone) begin
                        if (lastRead) begin
                            state     <= AcqIdle;
                            rdCnt     <= '0;
                            frameDone <= 1'b1;
                        end else begin
                            rdCnt    <= rdCnt + 1'b1;
                            rdStrobe <= 1'b1;
                        end
                    end
                end

                default: begin
                    state <= AcqIdle;
                end
            endcase
        end
    end

endmodule

// File: rtl/byteSender.sv
`timescale 1ns/1ps

module byteSender
    import fdaPkg::*;
#(
    parameter int ByteGap = 4
) (
    input  logic    ClkADC2DCM,
    input  logic    fifoRecord,
    input  logic    load,
    input  adcWordT loadWord,
    output byteT    txByte,
    output logic    txStrobe,
    output logic    wordDone
);

    // Counter must also hold the longer gap after a word
    localparam int GapW = $clog2(ByteGap + 1);
    localparam int IdxW = $clog2(LanesPerWord);

    adcWordT         shiftReg;
    logic [GapW-1:0] gapCnt;
    logic [IdxW-1:0] byteIdx;
    logic            busy;

    logic    take;
    logic    gapDone;
    logic    fire;
    logic    lastByte;
    adcWordT srcWord;

    // Load accepted only while idle, otherwise dropped
    assign take     = load && !busy;
    assign gapDone  = (gapCnt == '0);
    // Byte goes out once the gap has run down
    assign fire     = gapDone && (busy || take);
    assign lastByte = (byteIdx == IdxW'(LanesPerWord - 1));

    // Fresh word bypasses the shift register on the first byte
    assign srcWord = busy ? shiftReg : loadWord;

    // ----------------------------------------------------------------------
    // Pacing control
    // ----------------------------------------------------------------------

    always_ff @(posedge ClkADC2DCM or posedge fifoRecord) begin
        if (fifoRecord) begin
            busy     <= 1'b0;
            gapCnt   <= '0;
            byteIdx  <= '0;
            txStrobe <= 1'b0;
            wordDone <= 1'b0;
        end else begin
            txStrobe <= fire;
            // Done flag rides with the fourth byte
            wordDone <= fire && lastByte;

            if (fire) begin
                // Index wraps back to zero after the last byte
                byteIdx <= byteIdx + 1'b1;
                busy    <= !lastByte;
                // One extra cycle of spacing before the next word
                if (lastByte) begin
                    gapCnt <= GapW'(ByteGap);
                end else begin
                    gapCnt <= GapW'(ByteGap - 1);
                end
            end else begin
                if (take) begin
                    // Held until the trailing gap expires
                    busy <= 1'b1;
                end
                if (!gapDone) begin
                    gapCnt <= gapCnt - 1'b1;
                end
            end
        end
    end

    // ----------------------------------------------------------------------
    // Byte datapath
    // ----------------------------------------------------------------------

    always_ff @(posedge ClkADC2DCM) begin
        if (fire) begin
            // Top byte out, rest moves up
            txByte   <= srcWord[WordW-1 -: SampleW];
            shiftReg <= srcWord << SampleW;
        end else if (take) begin
            shiftReg <= loadWord;
        end
    end

endmodule

// File: rtl/fdaAcquire.sv
`timescale 1ns/1ps

module fdaAcquire
    import fdaPkg::*;
#(
    // Words per record, power of two
    parameter int Depth = 16,
    // Cycles between bytes of one word, at least 2
    parameter int ByteGap = 4
) (
    input  logic     ClkADC2DCM,
    input  logic     fifoRecord,
    input  adcWordT  adcData,
    input  logic     testMode,
    input  logic     arm,
    input  logic     forceRecord,
    input  logic     triggerIn,
    output byteT     txByte,
    output logic     txStrobe,
    output logic     frameDone,
    output acqStateT acqState
);

    localparam int AddrW = $clog2(Depth);

    // Capture to control
    adcWordT sampleWord;
    logic    trigEdge;

    // Control to memory
    logic             wrEn;
    logic [AddrW-1:0] wrAddr;
    adcWordT          wrWord;
    logic             rdStrobe;
    logic [AddrW-1:0] rdAddr;

    // Memory to sender, sender back to control
    adcWordT rdWord;
    logic    rdValid;
    logic    wordDone;

    // ----------------------------------------------------------------------
    // Input side
    // ----------------------------------------------------------------------

    sampleCapture uCapture (
        .ClkADC2DCM (ClkADC2DCM),
        .fifoRecord (fifoRecord),
        .adcData    (adcData),
        .testMode   (testMode),
        .triggerIn  (triggerIn),
        .sampleWord (sampleWord),
        .trigEdge   (trigEdge)
    );

    // ----------------------------------------------------------------------
    // Record control and storage
    // ----------------------------------------------------------------------

    recordControl #(
        .Depth (Depth)
    ) uControl (
        .ClkADC2DCM  (ClkADC2DCM),
        .fifoRecord  (fifoRecord),
        .arm         (arm),
        .forceRecord (forceRecord),
        .trigEdge    (trigEdge),
        .sampleWord  (sampleWord),
        .wordDone    (wordDone),
        .wrEn        (wrEn),
        .wrAddr      (wrAddr),
        .wrWord      (wrWord),
        .rdStrobe    (rdStrobe),
        .rdAddr      (rdAddr),
        .frameDone   (frameDone),
        .acqState    (acqState)
    );

    sampleMemory #(
        .Depth (Depth)
    ) uMemory (
        .ClkADC2DCM (ClkADC2DCM),
        .fifoRecord (fifoRecord),
        .wrEn       (wrEn),
        .wrAddr     (wrAddr),
        .wrWord     (wrWord),
        .rdStrobe   (rdStrobe),
        .rdAddr     (rdAddr),
        .rdWord     (rdWord),
        .rdValid    (rdValid)
    );

    // ----------------------------------------------------------------------
    // Output side
    // ----------------------------------------------------------------------

    // Read data doubles as the load strobe
    byteSender #(
        .ByteGap (ByteGap)
    ) uSender (
        .ClkADC2DCM (ClkADC2DCM),
        .fifoRecord (fifoRecord),
        .load       (rdValid),
        .loadWord   (rdWord),
        .txByte     (txByte),
        .txStrobe   (txStrobe),
        .wordDone   (wordDone)
    );

endmodule

// File: verif/fdaAcquireTb.sv
`timescale 1ns/1ps

module fdaAcquireTb
    import fdaPkg::*;
();

    localparam int Depth = 16;
    localparam int ByteGap = 4;
    // Normal, test mode, trigger, aborted and repeat record
    localparam int Records = 5;
    // Store phase plus paced readout per record, with slack for idle windows
    localparam int CycleLimit = Records * Depth * (4 * ByteGap + 4) + 800;

    logic     ClkADC2DCM;
    logic     fifoRecord;
    adcWordT  adcData;
    logic     testMode;
    logic     arm;
    logic     forceRecord;
    logic     triggerIn;
    byteT     txByte;
    logic     txStrobe;
    logic     frameDone;
    acqStateT acqState;

    // Word seen by the DUT at each rising edge, oldest first
    adcWordT hist[$];
    // Bytes still due on txByte
    byteT    expQ[$];
    byteT    expByte;
    // Expected ramp value in front of the next edge
    sampleT  rampModel = '0;

    int cyc = 0;
    int errors = 0;
    int frames = 0;
    int bytesSeen = 0;
    int recBytes = 0;
    int lastStrobe = 0;

    fdaAcquire #(
        .Depth   (Depth),
        .ByteGap (ByteGap)
    ) DUT (.*);

    initial begin
        ClkADC2DCM = 1'b0;
        forever #20 ClkADC2DCM = ~ClkADC2DCM;
    end

    // ----------------------------------------------------------------------
    // Reference history, sampled where inputs are stable
    // ----------------------------------------------------------------------

    always @(negedge ClkADC2DCM) begin
        if (testMode) begin
            hist.push_back({4{rampModel}});
        end else begin
            hist.push_back(adcData);
        end
        // Ramp after the coming edge, held at zero in reset
        rampModel = fifoRecord ? '0 : rampModel + 1'b1;
    end

    // ----------------------------------------------------------------------
    // Output checks
    // ----------------------------------------------------------------------

    always @(negedge ClkADC2DCM) begin
        cyc++;
        if (fifoRecord) begin
            assert (acqState == AcqIdle && !txStrobe && !frameDone) else begin
                errors++;
                $display("Outputs not quiet during reset at %0t", $time);
            end
            recBytes = 0;
        end
        if (txStrobe) begin
            assert (expQ.size() != 0) else begin
                errors++;
                $display("Unexpected byte 0x%02h at %0t", txByte, $time);
            end
            if (expQ.size() != 0) begin
                expByte = expQ.pop_front();
                assert (txByte == expByte) else begin
                    errors++;
                    $display("Mismatch at %0t: txByte expected 0x%02h, got 0x%02h",
                             $time, expByte, txByte);
                end
            end
            // Fixed pacing inside a word, longer pause between words
            if (recBytes % 4 != 0) begin
                assert (cyc - lastStrobe == ByteGap) else begin
                    errors++;
                    $display("Byte spacing of %0d cycles inside a word at %0t",
                             cyc - lastStrobe, $time);
                end
            end else if (recBytes != 0) begin
                assert (cyc - lastStrobe > ByteGap) else begin
                    errors++;
                    $display("Word spacing too short at %0t", $time);
                end
            end
            lastStrobe = cyc;
            recBytes++;
            bytesSeen++;
        end
        if (frameDone) begin
            assert (expQ.size() == 0 && recBytes == 4 * Depth && lastStrobe == cyc - 1
                    && acqState == AcqIdle) else begin
                errors++;
                $display("Frame end out of place at %0t after %0d bytes", $time, recBytes);
            end
            frames++;
            recBytes = 0;
        end
    end

    // ----------------------------------------------------------------------
    // Stimulus helpers
    // ----------------------------------------------------------------------

    // Advance n edges and land just after the last one
    task automatic tick(int n);
        repeat (n) @(posedge ClkADC2DCM);
        #2;
    endtask

    // FSM state seen on the top level output
    task automatic checkState(acqStateT expState);
        assert (acqState == expState) else begin
            errors++;
            $display("Mismatch at %0t: acqState expected %0d, got %0d",
                     $time, expState, acqState);
        end
    endtask

    // Queue Depth words from history, top byte first
    task automatic expectRecord(int startIdx);
        adcWordT word;
        while (hist.size() < startIdx + Depth) begin
            tick(1);
        end
        for (int w = 0; w < Depth; w++) begin
            word = hist[startIdx + w];
            for (int b = 3; b >= 0; b--) begin
                expQ.push_back(word[b*8 +: 8]);
            end
        end
    endtask

    task automatic forcedRecord();
        int startIdx;
        // Next history entry is the word at the strobe edge
        startIdx = hist.size();
        forceRecord = 1'b1;
        tick(1);
        forceRecord = 1'b0;
        expectRecord(startIdx);
    endtask

    task automatic waitFrames(int n);
        while (frames < n) begin
            tick(1);
        end
    endtask

    task automatic pulseTrigger(int width);
        triggerIn = 1'b1;
        tick(width);
        triggerIn = 1'b0;
        tick(4);
    endtask

    // Fresh random word after every edge
    initial begin
        forever begin
            @(posedge ClkADC2DCM);
            #2 adcData = $urandom;
        end
    end

    initial begin
        wait (cyc >= CycleLimit);
        $display("Timeout after %0d cycles: %0d errors, %0d frames done",
                 CycleLimit, errors, frames);
        $display("tests failed");
        $finish;
    end

    // ----------------------------------------------------------------------
    // Test sequence
    // ----------------------------------------------------------------------

    initial begin
        int startIdx;
        int baseBytes;
        void'($urandom(32'h5b1e139b));
        fifoRecord  = 1'b1;
        adcData     = '0;
        testMode    = 1'b0;
        arm         = 1'b0;
        forceRecord = 1'b0;
        triggerIn   = 1'b0;
        tick(16);
        fifoRecord = 1'b0;
        tick(20);
        checkState(AcqIdle);

        // Random data record
        forcedRecord();
        waitFrames(1);

        // Ramp record
        testMode = 1'b1;
        tick(3);
        forcedRecord();
        testMode = 1'b0;
        waitFrames(2);

        // Trigger without arm is ignored
        baseBytes = bytesSeen;
        pulseTrigger(3);
        pulseTrigger(6);
        tick(40);
        assert (bytesSeen == baseBytes && acqState == AcqIdle) else begin
            errors++;
            $display("Trigger while idle started a record");
        end

        // Armed trigger, edge reaches the FSM two edges after first sample
        arm = 1'b1;
        tick(1);
        arm = 1'b0;
        checkState(AcqArmed);
        tick(2);
        startIdx = hist.size() + 2;
        triggerIn = 1'b1;
        tick(5);
        checkState(AcqStore);
        arm = 1'b1;
        forceRecord = 1'b1;
        tick(1);
        arm = 1'b0;
        forceRecord = 1'b0;
        triggerIn = 1'b0;
        expectRecord(startIdx);
        tick(30);
        checkState(AcqSend);
        arm = 1'b1;
        forceRecord = 1'b1;
        tick(1);
        arm = 1'b0;
        forceRecord = 1'b0;
        waitFrames(3);
        baseBytes = bytesSeen;
        tick(60);
        assert (frames == 3 && bytesSeen == baseBytes) else begin
            errors++;
            $display("Strobes during a record started a second frame");
        end

        // Abort in the middle of the readout
        forcedRecord();
        while (bytesSeen < baseBytes + 10) begin
            tick(1);
        end
        fifoRecord = 1'b1;
        expQ.delete();
        tick(3);
        fifoRecord = 1'b0;
        tick(20);
        assert (acqState == AcqIdle && frames == 3) else begin
            errors++;
            $display("Reset did not abort the record");
        end
        forcedRecord();
        waitFrames(4);
        tick(10);

        assert (expQ.size() == 0) else begin
            errors++;
            $display("%0d bytes never arrived", expQ.size());
        end
        $display("Closing report: %0d errors, %0d frames, %0d bytes",
                 errors, frames, bytesSeen);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: src.f
rtl/fdaPkg.sv
rtl/sampleCapture.sv
rtl/sampleMemory.sv
rtl/recordControl.sv
rtl/byteSender.sv
rtl/fdaAcquire.sv
verif/fdaAcquireTb.sv

// File: Bender.yml
package:
  name: fdaAcquire

sources:
  - rtl/fdaPkg.sv
  - rtl/sampleCapture.sv
  - rtl/sampleMemory.sv
  - rtl/recordControl.sv
  - rtl/byteSender.sv
  - rtl/fdaAcquire.sv
  - target: test
    files:
      - verif/fdaAcquireTb.sv
